/* rtl/fill_pkg.sv */
package fill_pkg;

    // One memory response beat and one cache word.
    localparam int BEAT_BITS = 32;
    localparam int WORD_BITS = 128;

    // Beats packed into one cache word.
    localparam int CHUNKS = WORD_BITS / BEAT_BITS;

    localparam int WORD_ADDR_BITS = 10;
    localparam int ID_BITS = 2;

    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;

    // Word address in the upper bits, chunk index in the lower bits.
    typedef logic [WORD_ADDR_BITS+$clog2(CHUNKS)-1:0] beat_addr_t;

    typedef logic [CHUNKS-1:0] wmask_t;
    typedef logic [ID_BITS-1:0] fill_id_t;

    // A beat after address decode.
    typedef struct packed {
        beat_addr_t addr;
        fill_id_t   id;
        beat_t      data;
    } fill_beat_t;

    // SRAM write command. The strobes are active low.
    typedef struct packed {
        logic       ce_n;
        logic       we_n;
        wmask_t     wm;
        word_addr_t addr;
        word_t      data;
    } cache_wr_t;

endpackage

/* rtl/fill_beat_decoder.sv */
`timescale 1ns/1ps

module fill_beat_decoder
    import fill_pkg::*;
#(
    parameter int LINE_BEATS = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  fill_id_t   req_id,
    input  word_addr_t req_line,
    input  logic       beat_valid,
    input  fill_id_t   beat_id,
    input  beat_t      beat_data,
    input  logic       port_ready,
    output logic       beat_ready,
    output fill_beat_t beat,
    output logic       beat_fire
);

    localparam int CNT_BITS = $clog2(LINE_BEATS);
    localparam int IDS = 2 ** ID_BITS;

    typedef logic [CNT_BITS-1:0] beat_cnt_t;

    // Line start per id, and the position of the next beat within the line.
    word_addr_t base_r [IDS];
    beat_cnt_t  cnt_r  [IDS];

    assign beat_ready = port_ready;
    assign beat_fire  = beat_valid && port_ready;

    // The line start is word aligned, so the beat address is base * CHUNKS + count.
    assign beat.addr = beat_addr_t'({base_r[beat_id], {$clog2(CHUNKS){1'b0}}})
                     + beat_addr_t'(cnt_r[beat_id]);
    assign beat.id   = beat_id;
    assign beat.data = beat_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < IDS; i++) begin
                cnt_r[i] <= '0;
            end
        end else begin
            // The count wraps at the end of the line.
            if (beat_fire) begin
                cnt_r[beat_id] <= cnt_r[beat_id] + 1'b1;
            end
            // A new request restarts its id, even over a beat of the same id.
            if (req_valid) begin
                cnt_r[req_id] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            base_r[req_id] <= req_line;
        end
    end

endmodule

/* rtl/cache_write_port.sv */
`timescale 1ns/1ps

module cache_write_port
    import fill_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       beat_fire,
    input  fill_beat_t beat,
    input  logic       wr_ready,
    output logic       port_ready,
    output cache_wr_t  wr,
    output logic       ack_valid,
    output fill_id_t   ack_id
);

    localparam int CHUNK_BITS = $clog2(CHUNKS);
    localparam cache_wr_t WR_IDLE = '{ce_n: 1'b1, we_n: 1'b1, wm: '0, addr: '0, data: '0};

    typedef struct packed {
        word_t      data;
        word_addr_t addr;
        wmask_t     wm;
        logic       valid;
    } open_word_t;

    open_word_t cur_r;
    open_word_t cur_c;

    // A partial word flushed by a conflict while the SRAM was busy.
    cache_wr_t pend_r;
    cache_wr_t pend_c;

    word_addr_t            beat_word;
    logic [CHUNK_BITS-1:0] beat_chunk;
    logic                  pend_valid;
    logic                  cur_full;
    logic                  conflict;

    function automatic cache_wr_t issue(input open_word_t w);
        cache_wr_t c;
        c.ce_n = 1'b0;
        c.we_n = 1'b0;
        c.wm   = w.wm;
        c.addr = w.addr;
        c.data = w.data;
        return c;
    endfunction

    assign beat_word  = beat.addr[$bits(beat_addr_t)-1:CHUNK_BITS];
    assign beat_chunk = beat.addr[CHUNK_BITS-1:0];
    assign pend_valid = !pend_r.ce_n;

    // Beats of one id come in order, so a set top mask bit means the word is finished.
    assign cur_full   = cur_r.valid && cur_r.wm[CHUNKS-1];
    assign conflict   = cur_r.valid && (cur_r.addr != beat_word);
    assign port_ready = !pend_valid && !cur_full;

    always_comb begin
        cur_c  = cur_r;
        pend_c = pend_r;
        wr     = WR_IDLE;

        if (pend_valid) begin
            if (wr_ready) begin
                wr     = pend_r;
                pend_c = WR_IDLE;
            end
        end else if (cur_full) begin
            if (wr_ready) begin
                wr          = issue(cur_r);
                cur_c.valid = 1'b0;
            end
        end else if (beat_fire) begin
            if (conflict) begin
                // The partial word goes out with the chunks it has gathered so far.
                if (wr_ready) begin
                    wr = issue(cur_r);
                end else begin
                    pend_c = issue(cur_r);
                end
            end
            if (!cur_r.valid || conflict) begin
                cur_c.valid = 1'b1;
                cur_c.addr  = beat_word;
                cur_c.wm    = '0;
            end

            cur_c.data[beat_chunk*BEAT_BITS +: BEAT_BITS] = beat.data;
            cur_c.wm[beat_chunk] = 1'b1;

            // A last chunk that opened its own word waits one cycle behind the flush.
            if (!conflict && beat_chunk == CHUNK_BITS'(CHUNKS - 1) && wr_ready) begin
                wr          = issue(cur_c);
                cur_c.valid = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_r.valid <= 1'b0;
            pend_r      <= WR_IDLE;
            ack_valid   <= 1'b0;
        end else begin
            cur_r       <= cur_c;
            pend_r      <= pend_c;
            ack_valid   <= beat_fire;
        end
    end

    always_ff @(posedge clk) begin
        ack_id <= beat.id;
    end

endmodule

/* rtl/fill_completion_tracker.sv */
`timescale 1ns/1ps

module fill_completion_tracker
    import fill_pkg::*;
#(
    parameter int LINE_BEATS = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     ack_valid,
    input  fill_id_t ack_id,
    output logic     fill_done,
    output fill_id_t fill_done_id
);

    localparam int CNT_BITS = $clog2(LINE_BEATS);
    localparam int IDS = 2 ** ID_BITS;

    typedef logic [CNT_BITS-1:0] beat_cnt_t;

    beat_cnt_t ack_cnt_r [IDS];
    logic      line_full;

    // This ack carries the last beat of its line.
    assign line_full = ack_valid && (ack_cnt_r[ack_id] == beat_cnt_t'(LINE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < IDS; i++) begin
                ack_cnt_r[i] <= '0;
            end
            fill_done <= 1'b0;
        end else begin
            fill_done <= line_full;
            if (line_full) begin
                ack_cnt_r[ack_id] <= '0;
            end else if (ack_valid) begin
                ack_cnt_r[ack_id] <= ack_cnt_r[ack_id] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fill_done_id <= ack_id;
    end

endmodule

/* rtl/cache_data_ram.sv */
`timescale 1ns/1ps

module cache_data_ram
    import fill_pkg::*;
(
    input  logic       clk,
    input  cache_wr_t  wr,
    input  logic       rd_en,
    input  word_addr_t rd_addr,
    output logic       wr_ready,
    output word_t      rd_data
);

    localparam int DEPTH = 2 ** WORD_ADDR_BITS;

    word_t mem [DEPTH];

    // Single port: a read takes the array for the whole cycle.
    assign wr_ready = !rd_en;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end else if (!wr.ce_n && !wr.we_n) begin
            for (int i = 0; i < CHUNKS; i++) begin
                if (wr.wm[i]) begin
                    mem[wr.addr][i*BEAT_BITS +: BEAT_BITS] <= wr.data[i*BEAT_BITS +: BEAT_BITS];
                end
            end
        end
    end

endmodule

/* rtl/cache_fill_unit.sv */
`timescale 1ns/1ps

module cache_fill_unit
    import fill_pkg::*;
#(
    parameter int LINE_BEATS = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  fill_id_t   req_id,
    input  word_addr_t req_line,
    input  logic       beat_valid,
    input  fill_id_t   beat_id,
    input  beat_t      beat_data,
    input  logic       rd_en,
    input  word_addr_t rd_addr,
    output logic       beat_ready,
    output logic       ack_valid,
    output fill_id_t   ack_id,
    output logic       fill_done,
    output fill_id_t   fill_done_id,
    output word_t      rd_data
);

    logic       port_ready;
    logic       beat_fire;
    fill_beat_t beat;
    cache_wr_t  wr;
    logic       wr_ready;

    fill_beat_decoder #(
        .LINE_BEATS (LINE_BEATS)
    ) decoder_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_id     (req_id),
        .req_line   (req_line),
        .beat_valid (beat_valid),
        .beat_id    (beat_id),
        .beat_data  (beat_data),
        .port_ready (port_ready),
        .beat_ready (beat_ready),
        .beat       (beat),
        .beat_fire  (beat_fire)
    );

    cache_write_port write_port_i (
        .clk        (clk),
        .rst        (rst),
        .beat_fire  (beat_fire),
        .beat       (beat),
        .wr_ready   (wr_ready),
        .port_ready (port_ready),
        .wr         (wr),
        .ack_valid  (ack_valid),
        .ack_id     (ack_id)
    );

    fill_completion_tracker #(
        .LINE_BEATS (LINE_BEATS)
    ) tracker_i (
        .clk          (clk),
        .rst          (rst),
        .ack_valid    (ack_valid),
        .ack_id       (ack_id),
        .fill_done    (fill_done),
        .fill_done_id (fill_done_id)
    );

    cache_data_ram ram_i (
        .clk      (clk),
        .wr       (wr),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .wr_ready (wr_ready),
        .rd_data  (rd_data)
    );

endmodule

/* test/cache_fill_unit_tb.sv */
`timescale 1ns/1ps

module cache_fill_unit_tb
    import fill_pkg::*;
();

    localparam int LINE_BEATS = 16;
    localparam int TOTAL_BEATS = 10 * LINE_BEATS;
    localparam int DEPTH = 2 ** WORD_ADDR_BITS;

    logic       clk = 1'b0;
    logic       rst;
    logic       req_valid;
    fill_id_t   req_id;
    word_addr_t req_line;
    logic       beat_valid;
    fill_id_t   beat_id;
    beat_t      beat_data;
    logic       rd_en;
    word_addr_t rd_addr;
    logic       beat_ready;
    logic       ack_valid;
    fill_id_t   ack_id;
    logic       fill_done;
    fill_id_t   fill_done_id;
    word_t      rd_data;

    logic [31:0] lfsr_state = 32'haba3_9335;

    // Reference copy of the cache data, built from the accepted beats.
    word_t      model_mem [DEPTH];
    bit         settled   [DEPTH];
    word_addr_t base_m    [4];
    int         acc_cnt   [4];

    int errors = 0;
    int acks = 0;
    int dones = 0;
    int reqs = 0;
    int offered = 0;
    int rst_edges = 0;

    logic       acc_q = 1'b0;
    fill_id_t   acc_id_q = '0;
    logic       done1_q = 1'b0;
    logic       done2_q = 1'b0;
    fill_id_t   done1_id_q = '0;
    fill_id_t   done2_id_q = '0;
    logic       rd_q = 1'b0;
    word_addr_t rd_addr_q = '0;

    cache_fill_unit #(
        .LINE_BEATS (LINE_BEATS)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_id       (req_id),
        .req_line     (req_line),
        .beat_valid   (beat_valid),
        .beat_id      (beat_id),
        .beat_data    (beat_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .beat_ready   (beat_ready),
        .ack_valid    (ack_valid),
        .ack_id       (ack_id),
        .fill_done    (fill_done),
        .fill_done_id (fill_done_id),
        .rd_data      (rd_data)
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Sampled on the rising edge, so every value seen here settled in the cycle before.
    always @(posedge clk) begin : monitor
        int a;
        if (rst) begin
            if (rst_edges > 0) begin
                check_value("ack_valid", ack_valid, 1'b0);
                check_value("fill_done", fill_done, 1'b0);
                check_value("beat_ready", beat_ready, 1'b1);
            end
            rst_edges++;
        end else begin
            check_value("ack_valid", ack_valid, acc_q);
            if (acc_q) begin
                check_value("ack_id", ack_id, acc_id_q);
            end
            check_value("fill_done", fill_done, done2_q);
            if (done2_q) begin
                check_value("fill_done_id", fill_done_id, done2_id_q);
            end
            if (rd_q && settled[rd_addr_q]) begin
                check_value("rd_data", rd_data, model_mem[rd_addr_q]);
            end
            if (ack_valid) begin
                acks++;
            end
            if (fill_done) begin
                dones++;
            end
            done2_q = done1_q;
            done2_id_q = done1_id_q;
            done1_q = 1'b0;
            acc_q = beat_valid && beat_ready;
            acc_id_q = beat_id;
            if (acc_q) begin
                a = int'(base_m[beat_id]) * CHUNKS + acc_cnt[beat_id];
                model_mem[a / CHUNKS][(a % CHUNKS) * BEAT_BITS +: BEAT_BITS] = beat_data;
                acc_cnt[beat_id]++;
                if (acc_cnt[beat_id] == LINE_BEATS) begin
                    acc_cnt[beat_id] = 0;
                    done1_q = 1'b1;
                    done1_id_q = beat_id;
                end
            end
            // A request restarts its id after any beat of the same cycle.
            if (req_valid) begin
                base_m[req_id] = req_line;
                acc_cnt[req_id] = 0;
                reqs++;
            end
            rd_q = rd_en;
            rd_addr_q = rd_addr;
        end
    end

    // Requests nids lines, then sends their beats round robin over the ids.
    task automatic fill_lines(input int first_id, input int nids, input word_addr_t first_line,
                              input bit stress);
        int          sent [4];
        int          left;
        int          k;
        int          done_goal;
        bit          gap;
        bit          rd_on;
        logic [31:0] data;
        left = nids * LINE_BEATS;
        k = 0;
        rd_on = 1'b0;
        done_goal = dones + nids;
        for (int i = 0; i < nids; i++) begin
            sent[i] = 0;
            req_valid <= 1'b1;
            req_id <= fill_id_t'(first_id + i);
            req_line <= word_addr_t'(first_line + 4 * i);
            @(posedge clk);
        end
        req_valid <= 1'b0;
        data = take_bits(32);
        while (left > 0) begin
            while (sent[k] == LINE_BEATS) begin
                k = (k + 1) % nids;
            end
            gap = stress && (take_bits(3) == 0);
            if (stress && take_bits(2) == 0) begin
                rd_on = !rd_on;
            end
            beat_valid <= !gap;
            beat_id <= fill_id_t'(first_id + k);
            beat_data <= data;
            rd_en <= rd_on;
            rd_addr <= word_addr_t'(32'h040 + take_bits(4));
            @(posedge clk);
            if (!gap && beat_ready) begin
                sent[k]++;
                left--;
                offered++;
                k = (k + 1) % nids;
                data = take_bits(32);
            end
        end
        beat_valid <= 1'b0;
        rd_en <= 1'b0;
        while (dones < done_goal) begin
            @(posedge clk);
        end
        // Lets the last word reach the SRAM.
        repeat (4) @(posedge clk);
    endtask

    task automatic read_back(input word_addr_t first_word, input int nwords);
        for (int i = 0; i < nwords; i++) begin
            settled[word_addr_t'(first_word + i)] = 1'b1;
        end
        for (int i = 0; i < nwords; i++) begin
            rd_en <= 1'b1;
            rd_addr <= word_addr_t'(first_word + i);
            @(posedge clk);
        end
        rd_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    initial begin : main
        rst = 1'b1;
        req_valid = 1'b0;
        req_id = '0;
        req_line = '0;
        beat_valid = 1'b0;
        beat_id = '0;
        beat_data = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("beat_ready", beat_ready, 1'b1);

        for (int i = 0; i < 4; i++) begin
            fill_lines(i, 1, word_addr_t'(32'h040 + 4 * i), 1'b0);
        end
        read_back(10'h040, 16);

        fill_lines(0, 3, 10'h100, 1'b0);
        read_back(10'h100, 12);

        // Reads of the first lines hold off SRAM writes and stall the beats.
        fill_lines(1, 3, 10'h200, 1'b1);
        read_back(10'h200, 12);

        check_value("acks", acks, TOTAL_BEATS);
        check_value("fill_done count", dones, reqs);
        $display("Errors: %0d, beats %0d, acks %0d, fills done %0d of %0d",
                 errors, offered, acks, dones, reqs);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((TOTAL_BEATS * 40 + 16) * 8);
        $display("Timeout: the fills did not finish within %0d cycles.", TOTAL_BEATS * 40 + 16);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* list.f */
rtl/fill_pkg.sv
rtl/fill_beat_decoder.sv
rtl/cache_write_port.sv
rtl/fill_completion_tracker.sv
rtl/cache_data_ram.sv
rtl/cache_fill_unit.sv
test/cache_fill_unit_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module cache_fill_unit_tb -f list.f
	@out="$$(./obj_dir/Vcache_fill_unit_tb)"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
